/* hw/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    localparam int XLEN               = 32;
    localparam int MUL_CYCLES_DEFAULT = 32;  // One iteration per multiplier bit

    typedef logic [XLEN-1:0] data_t;
    typedef logic [XLEN-1:0] pc_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Uop layout from the LSB up
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int UOP_VALID_W    = 1;
    localparam int UOP_PC_W       = XLEN;
    localparam int UOP_TAKEN_W    = 1;   // Predicted direction
    localparam int UOP_OP1_SEL_W  = 3;
    localparam int UOP_OP2_SEL_W  = 3;
    localparam int UOP_RS1_W      = XLEN;
    localparam int UOP_RS2_W      = XLEN;
    localparam int UOP_IMM_W      = XLEN;
    localparam int UOP_ALU_OP_W   = 4;
    localparam int UOP_BR_OP_W    = 4;   // Nine branch ops
    localparam int UOP_MUL_OP_W   = 2;
    localparam int UOP_WB_SEL_W   = 2;
    localparam int UOP_RD_W       = XLEN; // Filled in by execute

    localparam int UOP_VALID_LSB   = 0;
    localparam int UOP_PC_LSB      = UOP_VALID_LSB + UOP_VALID_W;
    localparam int UOP_TAKEN_LSB   = UOP_PC_LSB + UOP_PC_W;
    localparam int UOP_OP1_SEL_LSB = UOP_TAKEN_LSB + UOP_TAKEN_W;
    localparam int UOP_OP2_SEL_LSB = UOP_OP1_SEL_LSB + UOP_OP1_SEL_W;
    localparam int UOP_RS1_LSB     = UOP_OP2_SEL_LSB + UOP_OP2_SEL_W;
    localparam int UOP_RS2_LSB     = UOP_RS1_LSB + UOP_RS1_W;
    localparam int UOP_IMM_LSB     = UOP_RS2_LSB + UOP_RS2_W;
    localparam int UOP_ALU_OP_LSB  = UOP_IMM_LSB + UOP_IMM_W;
    localparam int UOP_BR_OP_LSB   = UOP_ALU_OP_LSB + UOP_ALU_OP_W;
    localparam int UOP_MUL_OP_LSB  = UOP_BR_OP_LSB + UOP_BR_OP_W;
    localparam int UOP_WB_SEL_LSB  = UOP_MUL_OP_LSB + UOP_MUL_OP_W;
    localparam int UOP_RD_LSB      = UOP_WB_SEL_LSB + UOP_WB_SEL_W;
    localparam int UOP_BITS        = UOP_RD_LSB + UOP_RD_W;

    typedef logic [UOP_BITS-1:0] uop_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [UOP_OP1_SEL_W-1:0] {
        OPSEL_NONE, OPSEL_RS1, OPSEL_RS2, OPSEL_IMM, OPSEL_PC
    } opsel_e;

    typedef enum logic [UOP_ALU_OP_W-1:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [UOP_BR_OP_W-1:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
        BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } br_op_e;

    typedef enum logic [UOP_MUL_OP_W-1:0] {
        MUL_NONE, MUL_MUL, MUL_MULH, MUL_MULHU
    } mul_op_e;

    typedef enum logic [UOP_WB_SEL_W-1:0] {
        WB_ALU, WB_OP1, WB_LINK, WB_MUL
    } wb_sel_e;

endpackage

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu
    import exec_pkg::*;
(
    input  wire alu_op_e op_i,
    input  wire data_t   a_i,
    input  wire data_t   b_i,
    output data_t        result_o,
    output logic         eq_o,
    output logic         lt_o,
    output logic         ltu_o
);

    logic [4:0] shamt;
    data_t      sum;
    data_t      diff;

    assign shamt = b_i[4:0];
    assign sum   = a_i + b_i;
    assign diff  = a_i - b_i;

    // Compare flags that branch resolution also uses
    assign eq_o  = (a_i == b_i);
    assign lt_o  = ($signed(a_i) < $signed(b_i));
    assign ltu_o = (a_i < b_i);

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = sum;
            ALU_SUB:  result_o = diff;
            ALU_AND:  result_o = a_i & b_i;
            ALU_OR:   result_o = a_i | b_i;
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SRL:  result_o = a_i >> shamt;
            ALU_SRA:  result_o = data_t'($signed(a_i) >>> shamt);
            ALU_SLT:  result_o = data_t'(lt_o);   // Zero extended flag
            ALU_SLTU: result_o = data_t'(ltu_o);
            default:  result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit
    import exec_pkg::*;
(
    input  wire br_op_e op_i,
    input  wire pc_t    pc_i,
    input  wire data_t  base_i,
    input  wire data_t  imm_i,
    input  wire         pred_taken_i,
    input  wire         eq_i,
    input  wire         lt_i,
    input  wire         ltu_i,
    output logic        taken_o,
    output pc_t         target_o,
    output pc_t         link_o,
    output logic        mispredict_o,
    output logic        is_branch_o
);

    pc_t raw_target;

    // Resolved direction
    always_comb begin
        taken_o     = 1'b0;
        is_branch_o = 1'b1;
        case (op_i)
            BR_BEQ:  taken_o = eq_i;
            BR_BNE:  taken_o = !eq_i;
            BR_BLT:  taken_o = lt_i;
            BR_BGE:  taken_o = !lt_i;
            BR_BLTU: taken_o = ltu_i;
            BR_BGEU: taken_o = !ltu_i;
            BR_JAL,
            BR_JALR: taken_o = 1'b1;     // Jumps always taken
            default: is_branch_o = 1'b0;
        endcase
    end

    assign raw_target = pc_t'(base_i + imm_i);

    always_comb begin
        target_o = raw_target;
        if (op_i == BR_JALR) begin
            target_o[0] = 1'b0;          // JALR clears the LSB
        end
    end

    assign link_o = pc_i + pc_t'(4);

    // Only the direction is predicted
    assign mispredict_o = is_branch_o && (taken_o != pred_taken_i);

endmodule

`default_nettype wire

/* hw/mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_unit
    import exec_pkg::*;
#(
    parameter int MUL_CYCLES = MUL_CYCLES_DEFAULT
) (
    input  wire          clk_i,
    input  wire          rstn_i,
    input  wire          valid_i,
    input  wire mul_op_e op_i,
    input  wire data_t   a_i,
    input  wire data_t   b_i,
    input  wire          accept_i,
    output logic         ready_o,
    output data_t        result_o
);

    localparam int CNT_W = $clog2(MUL_CYCLES + 1);

    typedef enum logic [1:0] {IDLE, BUSY, DONE} mul_state_e;

    mul_state_e          state_q;
    logic [CNT_W-1:0]    cnt_q;
    logic [2*XLEN-1:0]   mcand_q;
    logic [2*XLEN-1:0]   acc_q;
    logic [2*XLEN-1:0]   product;
    data_t               mplier_q;
    logic                neg_q;
    logic                a_neg;
    logic                b_neg;

    assign a_neg = (op_i == MUL_MULH) && a_i[XLEN-1];
    assign b_neg = (op_i == MUL_MULH) && b_i[XLEN-1];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: if (valid_i && op_i != MUL_NONE) begin
                    state_q <= BUSY;
                    cnt_q   <= '0;
                end
                BUSY: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(MUL_CYCLES - 1)) state_q <= DONE;
                end
                DONE: if (accept_i) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // Shift-add datapath on operand magnitudes
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE) begin
            mcand_q  <= {{XLEN{1'b0}}, (a_neg ? -a_i : a_i)};
            mplier_q <= b_neg ? -b_i : b_i;
            acc_q    <= '0;
            neg_q    <= a_neg ^ b_neg;
        end else if (state_q == BUSY) begin
            if (mplier_q[0]) acc_q <= acc_q + mcand_q;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign product  = neg_q ? -acc_q : acc_q;  // Sign fix for MULH
    assign result_o = (op_i == MUL_MUL) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];

    assign ready_o = (state_q == DONE) ||
                     (state_q == IDLE && (!valid_i || op_i == MUL_NONE));

endmodule

`default_nettype wire

/* hw/exec_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_stage
    import exec_pkg::*;
#(
    parameter int MUL_CYCLES = MUL_CYCLES_DEFAULT
) (
    input  wire       clk_i,
    input  wire       rstn_i,
    input  wire       hold_i,
    input  wire uop_t uop_i,
    output logic      stall_o,
    output logic      flush_o,
    output logic      redirect_valid_o,
    output pc_t       redirect_pc_o,
    output logic      bp_update_o,
    output pc_t       bp_pc_o,
    output logic      bp_taken_o,
    output pc_t       bp_target_o,
    output uop_t      uop_o
);

    uop_t    uop_q;
    uop_t    uop_d;

    logic    uop_valid;
    pc_t     uop_pc;
    logic    uop_taken;
    opsel_e  op1_sel;
    opsel_e  op2_sel;
    data_t   rs1;
    data_t   rs2;
    data_t   imm;
    alu_op_e alu_op;
    br_op_e  br_op;
    mul_op_e mul_op;
    wb_sel_e wb_sel;

    data_t   op1;
    data_t   op2;
    data_t   alu_result;
    logic    alu_eq;
    logic    alu_lt;
    logic    alu_ltu;
    data_t   br_base;
    logic    br_taken;
    pc_t     br_target;
    pc_t     br_link;
    logic    br_mispredict;
    logic    br_is_branch;
    logic    mul_ready;
    data_t   mul_result;
    data_t   rd_val;

    function automatic data_t sel_operand(input opsel_e sel, input data_t r1, input data_t r2,
                                          input data_t im, input pc_t pc);
        case (sel)
            OPSEL_RS1: return r1;
            OPSEL_RS2: return r2;
            OPSEL_IMM: return im;
            OPSEL_PC:  return data_t'(pc);
            default:   return '0;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Uop unpack and operand select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign uop_valid = uop_i[UOP_VALID_LSB];
    assign uop_pc    = uop_i[UOP_PC_LSB +: UOP_PC_W];
    assign uop_taken = uop_i[UOP_TAKEN_LSB];
    assign op1_sel   = opsel_e'(uop_i[UOP_OP1_SEL_LSB +: UOP_OP1_SEL_W]);
    assign op2_sel   = opsel_e'(uop_i[UOP_OP2_SEL_LSB +: UOP_OP2_SEL_W]);
    assign rs1       = uop_i[UOP_RS1_LSB +: UOP_RS1_W];
    assign rs2       = uop_i[UOP_RS2_LSB +: UOP_RS2_W];
    assign imm       = uop_i[UOP_IMM_LSB +: UOP_IMM_W];
    assign alu_op    = alu_op_e'(uop_i[UOP_ALU_OP_LSB +: UOP_ALU_OP_W]);
    assign br_op     = br_op_e'(uop_i[UOP_BR_OP_LSB +: UOP_BR_OP_W]);
    assign mul_op    = mul_op_e'(uop_i[UOP_MUL_OP_LSB +: UOP_MUL_OP_W]);
    assign wb_sel    = wb_sel_e'(uop_i[UOP_WB_SEL_LSB +: UOP_WB_SEL_W]);

    assign op1     = sel_operand(op1_sel, rs1, rs2, imm, uop_pc);
    assign op2     = sel_operand(op2_sel, rs1, rs2, imm, uop_pc);
    assign br_base = (br_op == BR_JALR) ? rs1 : data_t'(uop_pc);

    alu u_alu (
        .op_i     (alu_op),
        .a_i      (op1),
        .b_i      (op2),
        .result_o (alu_result),
        .eq_o     (alu_eq),
        .lt_o     (alu_lt),
        .ltu_o    (alu_ltu)
    );

    branch_unit u_branch (
        .op_i         (br_op),
        .pc_i         (uop_pc),
        .base_i       (br_base),
        .imm_i        (imm),
        .pred_taken_i (uop_taken),
        .eq_i         (alu_eq),
        .lt_i         (alu_lt),
        .ltu_i        (alu_ltu),
        .taken_o      (br_taken),
        .target_o     (br_target),
        .link_o       (br_link),
        .mispredict_o (br_mispredict),
        .is_branch_o  (br_is_branch)
    );

    mul_unit #(
        .MUL_CYCLES (MUL_CYCLES)
    ) u_mul (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .valid_i  (uop_valid),
        .op_i     (mul_op),
        .a_i      (rs1),
        .b_i      (rs2),
        .accept_i (!hold_i),     // Leaves DONE when the uop is registered
        .ready_o  (mul_ready),
        .result_o (mul_result)
    );

    // Feedback toward fetch and issue
    assign stall_o          = uop_valid && !mul_ready;
    assign flush_o          = uop_valid && br_mispredict;
    assign redirect_valid_o = flush_o;
    assign redirect_pc_o    = br_taken ? br_target : br_link;
    assign bp_update_o      = uop_valid && br_is_branch;
    assign bp_pc_o          = uop_pc;
    assign bp_taken_o       = uop_valid && br_taken;
    assign bp_target_o      = br_target;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write-back select and uop register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (wb_sel)
            WB_OP1:  rd_val = op1;
            WB_LINK: rd_val = data_t'(br_link);
            WB_MUL:  rd_val = mul_result;
            default: rd_val = alu_result;
        endcase
    end

    always_comb begin
        uop_d                           = uop_i;
        uop_d[UOP_RD_LSB +: UOP_RD_W]   = rd_val;
        uop_d[UOP_VALID_LSB]            = uop_valid && !stall_o;  // Bubble while stalled
        if (hold_i) uop_d = uop_q;
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            uop_q <= '0;
        end else begin
            uop_q <= uop_d;
        end
    end

    assign uop_o = uop_q;

endmodule

`default_nettype wire

/* hw/exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_top
    import exec_pkg::*;
#(
    parameter int MUL_CYCLES = MUL_CYCLES_DEFAULT
) (
    input  wire       clk_i,
    input  wire       rstn_i,
    input  wire       hold_i,
    input  wire uop_t uop_i,
    output logic      stall_o,
    output logic      flush_o,
    output logic      redirect_valid_o,
    output pc_t       redirect_pc_o,
    output logic      bp_update_o,
    output pc_t       bp_pc_o,
    output logic      bp_taken_o,
    output pc_t       bp_target_o,
    output uop_t      uop_o
);

    exec_stage #(
        .MUL_CYCLES (MUL_CYCLES)
    ) u_exec (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .hold_i           (hold_i),
        .uop_i            (uop_i),
        .stall_o          (stall_o),
        .flush_o          (flush_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .bp_update_o      (bp_update_o),
        .bp_pc_o          (bp_pc_o),
        .bp_taken_o       (bp_taken_o),
        .bp_target_o      (bp_target_o),
        .uop_o            (uop_o)
    );

endmodule

`default_nettype wire

/* tb/exec_ref.svh */
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expected results of one uop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
function automatic data_t operand_ref(input logic [UOP_OP1_SEL_W-1:0] sel, input uop_t u);
    case (sel)
        OPSEL_RS1: return u[UOP_RS1_LSB +: UOP_RS1_W];
        OPSEL_RS2: return u[UOP_RS2_LSB +: UOP_RS2_W];
        OPSEL_IMM: return u[UOP_IMM_LSB +: UOP_IMM_W];
        OPSEL_PC:  return u[UOP_PC_LSB +: UOP_PC_W];
        default:   return '0;   // NONE reads as zero
    endcase
endfunction

function automatic data_t alu_ref(input logic [UOP_ALU_OP_W-1:0] op, input data_t a,
                                  input data_t b);
    case (op)
        ALU_ADD:  return a + b;
        ALU_SUB:  return a - b;
        ALU_AND:  return a & b;
        ALU_OR:   return a | b;
        ALU_XOR:  return a ^ b;
        ALU_SLL:  return a << b[4:0];
        ALU_SRL:  return a >> b[4:0];
        ALU_SRA:  return data_t'($signed(a) >>> b[4:0]);
        ALU_SLT:  return ($signed(a) < $signed(b)) ? data_t'(1) : data_t'(0);
        ALU_SLTU: return (a < b) ? data_t'(1) : data_t'(0);
        default:  return '0;
    endcase
endfunction

function automatic data_t mul_ref(input logic [UOP_MUL_OP_W-1:0] op, input data_t a,
                                  input data_t b);
    logic signed [2*XLEN-1:0] sprod;
    logic [2*XLEN-1:0]        uprod;
    sprod = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{b[XLEN-1]}}, b});
    uprod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    case (op)
        MUL_MUL:   return uprod[XLEN-1:0];
        MUL_MULH:  return sprod[2*XLEN-1:XLEN];
        MUL_MULHU: return uprod[2*XLEN-1:XLEN];
        default:   return '0;
    endcase
endfunction

// Branch flags compare the two selected operands
function automatic logic taken_ref(input uop_t u);
    data_t a;
    data_t b;
    a = operand_ref(u[UOP_OP1_SEL_LSB +: UOP_OP1_SEL_W], u);
    b = operand_ref(u[UOP_OP2_SEL_LSB +: UOP_OP2_SEL_W], u);
    case (u[UOP_BR_OP_LSB +: UOP_BR_OP_W])
        BR_BEQ:  return a == b;
        BR_BNE:  return a != b;
        BR_BLT:  return $signed(a) < $signed(b);
        BR_BGE:  return $signed(a) >= $signed(b);
        BR_BLTU: return a < b;
        BR_BGEU: return a >= b;
        BR_JAL,
        BR_JALR: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic pc_t target_ref(input uop_t u);
    pc_t base;
    pc_t tgt;
    logic is_jalr;
    is_jalr = (u[UOP_BR_OP_LSB +: UOP_BR_OP_W] == BR_JALR);
    base    = is_jalr ? u[UOP_RS1_LSB +: UOP_RS1_W] : u[UOP_PC_LSB +: UOP_PC_W];
    tgt     = base + u[UOP_IMM_LSB +: UOP_IMM_W];
    if (is_jalr) tgt[0] = 1'b0;
    return tgt;
endfunction

function automatic data_t rd_ref(input uop_t u);
    data_t a;
    data_t b;
    a = operand_ref(u[UOP_OP1_SEL_LSB +: UOP_OP1_SEL_W], u);
    b = operand_ref(u[UOP_OP2_SEL_LSB +: UOP_OP2_SEL_W], u);
    case (u[UOP_WB_SEL_LSB +: UOP_WB_SEL_W])
        WB_OP1:  return a;
        WB_LINK: return u[UOP_PC_LSB +: UOP_PC_W] + data_t'(4);
        WB_MUL:  return mul_ref(u[UOP_MUL_OP_LSB +: UOP_MUL_OP_W],
                                u[UOP_RS1_LSB +: UOP_RS1_W], u[UOP_RS2_LSB +: UOP_RS2_W]);
        default: return alu_ref(u[UOP_ALU_OP_LSB +: UOP_ALU_OP_W], a, b);
    endcase
endfunction

`endif

/* tb/exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_tb
    import exec_pkg::*;
();

    localparam int MUL_CYCLES     = MUL_CYCLES_DEFAULT;
    localparam int N_IDLE         = 20;
    localparam int N_ALU          = 200;
    localparam int N_BR           = 150;
    localparam int N_MUL          = 40;
    localparam int N_UOPS         = N_IDLE + N_ALU + N_BR + N_MUL;
    localparam int TIMEOUT_CYCLES = N_UOPS * (MUL_CYCLES + 4) + 100;

    logic   clk_i;
    logic   rstn_i;
    logic   hold_i;
    uop_t   uop_i;
    logic   stall_o;
    logic   flush_o;
    logic   redirect_valid_o;
    pc_t    redirect_pc_o;
    logic   bp_update_o;
    pc_t    bp_pc_o;
    logic   bp_taken_o;
    pc_t    bp_target_o;
    uop_t   uop_o;

    integer seed;
    logic   hold_en;
    uop_t   exp_q[$];
    uop_t   last_uop;
    int     value_errs;
    int     other_errs;
    int     checked;

    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    exec_top #(
        .MUL_CYCLES (MUL_CYCLES)
    ) exec_top_i (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .hold_i           (hold_i),
        .uop_i            (uop_i),
        .stall_o          (stall_o),
        .flush_o          (flush_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .bp_update_o      (bp_update_o),
        .bp_pc_o          (bp_pc_o),
        .bp_taken_o       (bp_taken_o),
        .bp_target_o      (bp_target_o),
        .uop_o            (uop_o)
    );

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_uop(input string name, input uop_t got, input uop_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic data_t rand_data();
        return data_t'($random(seed));
    endfunction

    function automatic data_t edge_data();
        case (rand_below(4))
            0:       return '0;
            1:       return '1;
            2:       return {1'b1, {(XLEN-1){1'b0}}};   // Most negative
            default: return rand_data();
        endcase
    endfunction

    function automatic uop_t make_uop(input logic valid, input int s1, input int s2,
                                      input int aop, input int bop, input int mop,
                                      input int wb, input data_t rs1, input data_t rs2);
        uop_t u;
        u = '0;
        u[UOP_VALID_LSB]                    = valid;
        u[UOP_PC_LSB +: UOP_PC_W]           = rand_data() & ~data_t'(3);
        u[UOP_TAKEN_LSB]                    = (rand_below(2) == 1);
        u[UOP_OP1_SEL_LSB +: UOP_OP1_SEL_W] = UOP_OP1_SEL_W'(s1);
        u[UOP_OP2_SEL_LSB +: UOP_OP2_SEL_W] = UOP_OP2_SEL_W'(s2);
        u[UOP_RS1_LSB +: UOP_RS1_W]         = rs1;
        u[UOP_RS2_LSB +: UOP_RS2_W]         = rs2;
        u[UOP_IMM_LSB +: UOP_IMM_W]         = rand_data();
        u[UOP_ALU_OP_LSB +: UOP_ALU_OP_W]   = UOP_ALU_OP_W'(aop);
        u[UOP_BR_OP_LSB +: UOP_BR_OP_W]     = UOP_BR_OP_W'(bop);
        u[UOP_MUL_OP_LSB +: UOP_MUL_OP_W]   = UOP_MUL_OP_W'(mop);
        u[UOP_WB_SEL_LSB +: UOP_WB_SEL_W]   = UOP_WB_SEL_W'(wb);
        u[UOP_RD_LSB +: UOP_RD_W]           = rand_data();  // Stale slot that execute overwrites
        return u;
    endfunction

    task automatic check_feedback(input uop_t u, input logic exp_stall);
        logic valid;
        logic is_br;
        logic taken;
        logic mis;
        pc_t  pc;
        pc_t  tgt;
        valid = u[UOP_VALID_LSB];
        pc    = u[UOP_PC_LSB +: UOP_PC_W];
        is_br = valid && (u[UOP_BR_OP_LSB +: UOP_BR_OP_W] != BR_NONE);
        taken = valid && taken_ref(u);
        tgt   = target_ref(u);
        mis   = is_br && (taken != u[UOP_TAKEN_LSB]);
        check_bit("stall_o", stall_o, exp_stall);
        check_bit("bp_update_o", bp_update_o, is_br);
        check_bit("bp_taken_o", bp_taken_o, taken);
        check_bit("flush_o", flush_o, mis);
        check_bit("redirect_valid_o", redirect_valid_o, mis);
        if (is_br) begin
            check_pc("bp_pc_o", bp_pc_o, pc);
            check_pc("bp_target_o", bp_target_o, tgt);
        end
        if (mis) check_pc("redirect_pc_o", redirect_pc_o, taken ? tgt : pc + pc_t'(4));
    endtask

    // Presents one uop until the stage takes it and checks feedback every cycle
    task automatic issue(input uop_t u);
        logic valid;
        logic is_mul;
        logic exp_stall;
        logic accept;
        logic done_held;
        int   stalls;
        uop_t exp_u;
        valid     = u[UOP_VALID_LSB];
        is_mul    = valid && (u[UOP_MUL_OP_LSB +: UOP_MUL_OP_W] != MUL_NONE);
        accept    = 1'b0;
        done_held = 1'b0;
        stalls    = 0;
        exp_u     = u;
        exp_u[UOP_RD_LSB +: UOP_RD_W] = rd_ref(u);
        uop_i = u;
        while (!accept) begin
            @(negedge clk_i);
            exp_stall = is_mul && (stalls <= MUL_CYCLES);  // IDLE cycle plus BUSY cycles
            check_feedback(u, exp_stall);
            if (exp_stall) stalls++;
            accept = !valid || (!hold_i && !stall_o);
            @(posedge clk_i);
            #1;
            if (accept && valid) exp_q.push_back(exp_u);
            if (is_mul && stalls == MUL_CYCLES + 1 && !done_held) begin
                hold_i    = hold_en;                       // Hold lands in DONE
                done_held = 1'b1;
            end else begin
                hold_i = hold_en && (rand_below(4) == 0);
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare process
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always begin : compare
        logic loaded;
        logic frozen;
        uop_t exp_u;
        uop_t got_u;
        @(posedge clk_i);
        loaded = rstn_i && !hold_i;
        frozen = rstn_i && hold_i;
        @(negedge clk_i);
        if (frozen) begin
            check_uop("uop_o", uop_o, last_uop);
        end else if (loaded && uop_o[UOP_VALID_LSB]) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("Valid uop on uop_o with none expected, uop duplicated or extra");
            end else begin
                exp_u = exp_q.pop_front();
                got_u = uop_o;
                got_u[UOP_RD_LSB +: UOP_RD_W] = exp_u[UOP_RD_LSB +: UOP_RD_W];
                check_data("uop_o.rd", uop_o[UOP_RD_LSB +: UOP_RD_W],
                           exp_u[UOP_RD_LSB +: UOP_RD_W]);
                check_uop("uop_o", got_u, exp_u);
                checked++;
            end
        end else if (loaded && exp_q.size() != 0) begin
            other_errs++;
            $display("Accepted uop missing on uop_o one cycle after issue");
            exp_q.delete(0);
        end
        last_uop = uop_o;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES + 10) @(posedge clk_i);
        $display("Timeout after %0d cycles, errors: %0d value, %0d other, %0d uops checked",
                 TIMEOUT_CYCLES, value_errs, other_errs, checked);
        $display("** FAIL **");
        $finish;
    end

    initial begin : stimulus
        int    bop;
        data_t r1;
        data_t r2;
        seed       = 32'he1ec0645;
        rstn_i     = 1'b0;
        hold_i     = 1'b0;
        hold_en    = 1'b0;
        uop_i      = '0;
        value_errs = 0;
        other_errs = 0;
        checked    = 0;
        repeat (10) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        @(negedge clk_i);
        check_bit("uop_o.valid", uop_o[UOP_VALID_LSB], 1'b0);
        @(posedge clk_i);
        #1;
        repeat (N_IDLE) begin                              // VALID low with any op
            issue(make_uop(1'b0, rand_below(5), rand_below(5), rand_below(10),
                           rand_below(9), rand_below(4), rand_below(4), rand_data(), rand_data()));
        end
        hold_en = 1'b1;
        repeat (N_ALU) begin
            issue(make_uop(1'b1, rand_below(5), rand_below(5), rand_below(10), BR_NONE,
                           MUL_NONE, rand_below(2), rand_data(), rand_data()));
        end
        repeat (N_BR) begin
            bop = 1 + rand_below(8);
            r1  = rand_data();
            r2  = (rand_below(4) == 0) ? r1 : rand_data();
            issue(make_uop(1'b1, OPSEL_RS1, OPSEL_RS2, rand_below(10), bop, MUL_NONE,
                           (bop >= BR_JAL) ? WB_LINK : WB_ALU, r1, r2));
        end
        repeat (N_MUL) begin
            issue(make_uop(1'b1, rand_below(5), rand_below(5), rand_below(10), BR_NONE,
                           1 + rand_below(3), WB_MUL, edge_data(), edge_data()));
        end
        uop_i  = '0;
        hold_i = 1'b0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        if (exp_q.size() != 0) begin
            other_errs++;
            $display("%0d accepted uops never reached uop_o", exp_q.size());
        end
        $display("Errors: %0d value, %0d other, %0d uops checked",
                 value_errs, other_errs, checked);
        if (value_errs == 0 && other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    `include "exec_ref.svh"

endmodule

`default_nettype wire

/* exec_top.f */
+incdir+tb
hw/exec_pkg.sv
hw/alu.sv
hw/branch_unit.sv
hw/mul_unit.sv
hw/exec_stage.sv
hw/exec_top.sv
tb/exec_tb.sv

/* run.sh */
#!/bin/sh
# Builds the execute stage testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module exec_tb -f exec_top.f -o Vexec_tb \
    && ./obj_dir/Vexec_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1
grep -q '\*\* PASS \*\*' sim.log || { echo "No result line in the log"; exit 1; }
exit 0
